/* design/vic_pkg.sv */
package vic_pkg;

  // raster geometry, kept tiny so a whole frame fits a short run
  localparam int h_total    = 64;  // dots per line
  localparam int v_total    = 40;  // lines per frame
  localparam int h_sync_len = 4;   // hsync high while x below this
  localparam int v_sync_len = 2;   // vsync high while y below this

  // display window, inclusive bounds
  localparam int win_x0 = 8;
  localparam int win_x1 = 55;
  localparam int win_y0 = 4;
  localparam int win_y1 = 35;

  localparam int x_width = 6;  // enough for h_total
  localparam int y_width = 6;  // enough for v_total

  // register map on the cpu bus
  localparam logic [5:0] reg_raster   = 6'h12;  // wr: compare line, rd: current line
  localparam logic [5:0] reg_irq_stat = 6'h19;  // bit 0 raster flag, write 1 to clear
  localparam logic [5:0] reg_irq_en   = 6'h1a;  // bit 0 raster irq enable
  localparam logic [5:0] reg_border   = 6'h20;  // border colour index
  localparam logic [5:0] reg_bg       = 6'h21;  // background colour index

  // fixed colour table, {red, green, blue} at 6 bits each
  localparam logic [17:0] palette [16] = '{
    {6'h00, 6'h00, 6'h00},  // black
    {6'h3f, 6'h3f, 6'h3f},  // white
    {6'h1a, 6'h0d, 6'h0a},  // red
    {6'h1c, 6'h29, 6'h2c},  // cyan
    {6'h1b, 6'h0f, 6'h21},  // purple
    {6'h16, 6'h23, 6'h10},  // green
    {6'h0d, 6'h0a, 6'h1e},  // blue
    {6'h2e, 6'h31, 6'h1b},  // yellow
    {6'h1b, 6'h13, 6'h09},  // orange
    {6'h10, 6'h0e, 6'h00},  // brown
    {6'h26, 6'h19, 6'h16},  // light red
    {6'h11, 6'h11, 6'h11},  // dark grey
    {6'h1b, 6'h1b, 6'h1b},  // mid grey
    {6'h26, 6'h34, 6'h21},  // light green
    {6'h1b, 6'h17, 6'h2d},  // light blue
    {6'h25, 6'h25, 6'h25}   // light grey
  };

endpackage : vic_pkg

/* design/vic_regs.sv */
module vic_regs import vic_pkg::*; (
  input  logic               clk_dot4x,
  input  logic               arst_n,
  input  logic               ce,          // chip enable, low active
  input  logic               rw,          // high read, low write
  input  logic [5:0]         adi,         // register address
  input  logic [7:0]         dbi,         // write data
  output logic [7:0]         dbo,         // read data, combinational
  input  logic [y_width-1:0] y,           // current raster line
  input  logic               line_start,  // first dot of a line
  output logic [3:0]         border_idx,
  output logic [3:0]         bg_idx,
  output logic               irq          // low active
);

  logic [y_width-1:0] raster_cmp;  // compare line
  logic               irq_stat;    // raster flag
  logic               irq_en;      // raster irq enable
  logic               wr;
  logic               raster_hit;
  logic               stat_clr;

  assign wr = ~ce & ~rw;  // write strobe, one per edge

  // flag raises on the edge after line_start of the compare line
  assign raster_hit = line_start && (y == raster_cmp);

  assign stat_clr = wr && (adi == reg_irq_stat) && dbi[0];  // write 1 to clear

  // plain config registers
  always_ff @(posedge clk_dot4x or negedge arst_n) begin
    if (!arst_n) begin
      raster_cmp <= '0;
      irq_en     <= 1'b0;
      border_idx <= 4'h0;
      bg_idx     <= 4'h0;
    end else if (wr) begin
      case (adi)
        reg_raster: raster_cmp <= dbi[y_width-1:0];  // upper bits dropped
        reg_irq_en: irq_en     <= dbi[0];
        reg_border: border_idx <= dbi[3:0];
        reg_bg:     bg_idx     <= dbi[3:0];
        default: ;  // other addresses are read only or unmapped
      endcase
    end
  end

  // status flag, set has priority over a clear in the same cycle
  always_ff @(posedge clk_dot4x or negedge arst_n) begin
    if (!arst_n) begin
      irq_stat <= 1'b0;
    end else if (raster_hit) begin
      irq_stat <= 1'b1;
    end else if (stat_clr) begin
      irq_stat <= 1'b0;
    end
  end

  // read mux, unused bits read back as ones
  always_comb begin
    case (adi)
      reg_raster:   dbo = 8'(y);  // current line, not the compare value
      reg_irq_stat: dbo = {7'h7f, irq_stat};
      reg_irq_en:   dbo = {7'h7f, irq_en};
      reg_border:   dbo = {4'hf, border_idx};
      reg_bg:       dbo = {4'hf, bg_idx};
      default:      dbo = 8'hff;  // unmapped
    endcase
  end

  // open collector style level, pulled low while flag and enable are set
  assign irq = ~(irq_stat & irq_en);

endmodule : vic_regs

/* design/raster_counter.sv */
module raster_counter import vic_pkg::*; (
  input  logic               clk_dot4x,
  input  logic               arst_n,
  output logic [x_width-1:0] x,           // dot within line
  output logic [y_width-1:0] y,           // line within frame
  output logic               hsync,
  output logic               vsync,
  output logic               active,
  output logic               line_start   // high while x is zero
);

  logic [x_width-1:0] x_nxt;
  logic [y_width-1:0] y_nxt;
  logic               x_wrap;

  assign x_wrap = (x == x_width'(h_total - 1));  // last dot of line

  always_comb begin
    x_nxt = x_wrap ? '0 : x + 1'b1;
    y_nxt = y;
    if (x_wrap) begin
      // next line, or back to top at end of frame
      y_nxt = (y == y_width'(v_total - 1)) ? '0 : y + 1'b1;
    end
  end

  // decoded outputs are registered from the next count so they line up with x/y
  always_ff @(posedge clk_dot4x or negedge arst_n) begin
    if (!arst_n) begin
      x          <= '0;
      y          <= '0;
      hsync      <= 1'b1;  // matches x = 0
      vsync      <= 1'b1;  // matches y = 0
      active     <= 1'b0;
      line_start <= 1'b1;
    end else begin
      x          <= x_nxt;
      y          <= y_nxt;
      hsync      <= (x_nxt < h_sync_len);
      vsync      <= (y_nxt < v_sync_len);
      active     <= (x_nxt >= h_sync_len) && (y_nxt >= v_sync_len);
      line_start <= (x_nxt == '0);
    end
  end

endmodule : raster_counter

/* design/pixel_color.sv */
module pixel_color import vic_pkg::*; (
  input  logic               clk_dot4x,
  input  logic               arst_n,
  input  logic [x_width-1:0] x,
  input  logic [y_width-1:0] y,
  input  logic               hsync_in,
  input  logic               vsync_in,
  input  logic               active_in,
  input  logic [3:0]         border_idx,
  input  logic [3:0]         bg_idx,
  output logic               hsync,      // delayed one dot
  output logic               vsync,      // delayed one dot
  output logic               active,     // delayed one dot
  output logic [5:0]         red,
  output logic [5:0]         green,
  output logic [5:0]         blue
);

  logic        in_win;
  logic [17:0] rgb;  // {red, green, blue}

  // window lies fully inside the active area
  assign in_win = (x >= win_x0) && (x <= win_x1) &&
                  (y >= win_y0) && (y <= win_y1);

  always_comb begin
    if (!active_in) begin
      rgb = '0;  // blanking
    end else if (in_win) begin
      rgb = palette[bg_idx];
    end else begin
      rgb = palette[border_idx];  // active but outside window
    end
  end

  // colour and sync registered together so they stay aligned
  always_ff @(posedge clk_dot4x or negedge arst_n) begin
    if (!arst_n) begin
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      active <= 1'b0;
      red    <= '0;
      green  <= '0;
      blue   <= '0;
    end else begin
      hsync  <= hsync_in;
      vsync  <= vsync_in;
      active <= active_in;
      red    <= rgb[17:12];
      green  <= rgb[11:6];
      blue   <= rgb[5:0];
    end
  end

endmodule : pixel_color

/* design/vicii.sv */
module vicii import vic_pkg::*; (
  input  logic       clk_dot4x,
  input  logic       arst_n,
  input  logic       ce,            // chip enable, low active
  input  logic       rw,            // high read, low write
  input  logic [5:0] adi,           // register address
  input  logic [7:0] dbi,           // data in from bus
  output logic [7:0] dbo,           // data out to bus
  output logic       vic_write_db,  // we drive the data bus
  output logic       irq,
  output logic       hsync,
  output logic       vsync,
  output logic       active,
  output logic [5:0] red,
  output logic [5:0] green,
  output logic [5:0] blue
);

  logic [x_width-1:0] x;
  logic [y_width-1:0] y;
  logic               raster_hsync;  // undelayed, straight from counters
  logic               raster_vsync;
  logic               raster_active;
  logic               line_start;
  logic [3:0]         border_idx;
  logic [3:0]         bg_idx;

  // cpu read cycle, the only place this is decoded
  assign vic_write_db = ~ce & rw;

  vic_regs i_regs (
    .clk_dot4x  (clk_dot4x),
    .arst_n     (arst_n),
    .ce         (ce),
    .rw         (rw),
    .adi        (adi),
    .dbi        (dbi),
    .dbo        (dbo),
    .y          (y),
    .line_start (line_start),
    .border_idx (border_idx),
    .bg_idx     (bg_idx),
    .irq        (irq)
  );

  raster_counter i_raster (
    .clk_dot4x  (clk_dot4x),
    .arst_n     (arst_n),
    .x          (x),
    .y          (y),
    .hsync      (raster_hsync),
    .vsync      (raster_vsync),
    .active     (raster_active),
    .line_start (line_start)
  );

  pixel_color i_color (
    .clk_dot4x  (clk_dot4x),
    .arst_n     (arst_n),
    .x          (x),
    .y          (y),
    .hsync_in   (raster_hsync),
    .vsync_in   (raster_vsync),
    .active_in  (raster_active),
    .border_idx (border_idx),
    .bg_idx     (bg_idx),
    .hsync      (hsync),
    .vsync      (vsync),
    .active     (active),
    .red        (red),
    .green      (green),
    .blue       (blue)
  );

endmodule : vicii

/* design/top.sv */
module top (
  input  logic       clk_dot4x,
  input  logic       arst_n,
  input  logic       ce,              // chip enable, low active
  input  logic       rw,              // high read, low write
  input  logic [5:0] adl,             // lower address lines
  inout  tri   [7:0] dbl,             // data bus, shared with cpu
  input  logic [3:0] dbh,             // colour nibble lines
  output logic       irq,             // low active
  output logic       cpu_reset,       // holds the cpu in reset
  output logic       ls245_data_dir,  // transceiver direction
  output logic       ls245_data_oe,   // transceiver enable, low active
  output logic       hsync,
  output logic       vsync,
  output logic       active,
  output logic [5:0] red,
  output logic [5:0] green,
  output logic [5:0] blue
);

  logic [7:0] dbo;
  logic [7:0] dbi;
  logic       vic_write_db;

  // upper nibble rides in on the colour lines, lower nibble on dbl
  assign dbi = {dbh, dbl[3:0]};

  vicii i_vicii (
    .clk_dot4x    (clk_dot4x),
    .arst_n       (arst_n),
    .ce           (ce),
    .rw           (rw),
    .adi          (adl),
    .dbi          (dbi),
    .dbo          (dbo),
    .vic_write_db (vic_write_db),
    .irq          (irq),
    .hsync        (hsync),
    .vsync        (vsync),
    .active       (active),
    .red          (red),
    .green        (green),
    .blue         (blue)
  );

  assign dbl = vic_write_db ? dbo : 8'bz;  // drive only on a cpu read
  assign ls245_data_dir = vic_write_db;     // towards the cpu while we drive
  assign ls245_data_oe  = 1'b0;             // transceiver always on
  assign cpu_reset      = ~arst_n;

endmodule : top

/* testbench/tb_top_properties.sv */
module tb_top_properties import vic_pkg::*; (
  input logic       clk_dot4x,
  input logic       arst_n,
  input logic       ce,
  input logic       vic_write_db,
  input logic       hsync,
  input logic       active,
  input logic [5:0] red,
  input logic [5:0] green,
  input logic [5:0] blue
);

  int fail_count = 0;  // read by tb_top for the closing summary

  // the core only turns the bus around while the chip is selected
  a_idle_no_drive: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
    ce |-> !vic_write_db)
    else begin
      fail_count++;
      $error("data bus turned around while chip enable is high");
    end

  // one sync pulse per line, h_sync_len dots wide
  a_hsync_width: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
    $rose(hsync) |-> hsync [*h_sync_len] ##1 !hsync)
    else begin
      fail_count++;
      $error("hsync pulse width differs from the line geometry");
    end

  a_blank_black: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
    !active |-> (red == '0) && (green == '0) && (blue == '0))  // blanking is black
    else begin
      fail_count++;
      $error("colour output not zero outside the active area");
    end

endmodule : tb_top_properties

/* testbench/tb_top.sv */
module tb_top import vic_pkg::*; ();

  localparam int frame_len     = h_total * v_total;       // dots per frame
  localparam int cycle_limit   = frame_len * 3 * 11 / 10;  // three frames plus 10%
  localparam int rand_accesses = 2000;
  localparam logic [5:0] reset_addrs [5] = '{reg_raster, reg_irq_stat, reg_irq_en,
                                             reg_border, reg_bg};

  logic        clk_dot4x;
  logic        arst_n;
  logic        ce;
  logic        rw;
  logic [5:0]  adl;
  wire  [7:0]  dbl;
  logic [3:0]  dbh;
  logic [7:0]  drv_data;  // byte the cpu puts on the bus
  logic        dbl_oe;    // cpu side drive enable
  logic        irq;
  logic        cpu_reset;
  logic        ls245_data_dir;
  logic        ls245_data_oe;
  logic        hsync;
  logic        vsync;
  logic        active;
  logic [5:0]  red;
  logic [5:0]  green;
  logic [5:0]  blue;
  integer      seed   = 32'hb9e00537;
  int          errors = 0;
  int          cycles = 0;
  int          m_x;       // model dot counter
  int          m_y;       // model line counter
  logic [5:0]  m_cmp;
  logic        m_stat;
  logic        m_en;
  logic [3:0]  m_border;
  logic [3:0]  m_bg;
  logic        exp_hs;    // expected outputs after the coming edge
  logic        exp_vs;
  logic        exp_act;
  logic [17:0] exp_rgb;

  assign dbl = dbl_oe ? drv_data : 8'bz;  // cpu side of the shared bus

  top i_dut (
    .clk_dot4x      (clk_dot4x),
    .arst_n         (arst_n),
    .ce             (ce),
    .rw             (rw),
    .adl            (adl),
    .dbl            (dbl),
    .dbh            (dbh),
    .irq            (irq),
    .cpu_reset      (cpu_reset),
    .ls245_data_dir (ls245_data_dir),
    .ls245_data_oe  (ls245_data_oe),
    .hsync          (hsync),
    .vsync          (vsync),
    .active         (active),
    .red            (red),
    .green          (green),
    .blue           (blue)
  );

  bind vicii tb_top_properties i_props (
    .clk_dot4x    (clk_dot4x),
    .arst_n       (arst_n),
    .ce           (ce),
    .vic_write_db (vic_write_db),
    .hsync        (hsync),
    .active       (active),
    .red          (red),
    .green        (green),
    .blue         (blue)
  );

  initial begin
    clk_dot4x = 1'b0;
    forever #50 clk_dot4x = ~clk_dot4x;
  end

  always @(posedge clk_dot4x) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // register contents as the cpu sees them, unused bits read as ones
  function automatic logic [7:0] read_value(input logic [5:0] addr);
    case (addr)
      reg_raster:   return 8'(m_y);  // current line, not the compare value
      reg_irq_stat: return {7'h7f, m_stat};
      reg_irq_en:   return {7'h7f, m_en};
      reg_border:   return {4'hf, m_border};
      reg_bg:       return {4'hf, m_bg};
      default:      return 8'hff;
    endcase
  endfunction

  function automatic logic [5:0] pick_addr(input logic [31:0] r);
    case (r[2:0])
      3'd0:    return reg_raster;
      3'd1:    return reg_irq_stat;
      3'd2:    return reg_irq_en;
      3'd3:    return reg_border;
      3'd4:    return reg_bg;
      default: return r[13:8];  // anywhere, mostly unmapped
    endcase
  endfunction

  task automatic check_outputs();
    check_value(hsync, exp_hs, "hsync");
    check_value(vsync, exp_vs, "vsync");
    check_value(active, exp_act, "active");
    check_value({red, green, blue}, exp_rgb, "pixel colour");
    check_value(irq, !(m_stat && m_en), "irq level");  // low while flag and enable set
    check_value(cpu_reset, !arst_n, "cpu reset");
    check_value(ls245_data_oe, 1'b0, "transceiver enable");
    if (!ce && rw) begin
      check_value(dbl, read_value(adl), $sformatf("read of address %0h", adl));
      check_value(ls245_data_dir, 1'b1, "transceiver direction on read");
    end else if (ce) begin
      check_value(dbl, 8'bz, "idle data bus");
      check_value(ls245_data_dir, 1'b0, "transceiver direction when idle");
    end
  endtask

  // what the coming rising edge does, seen from the inputs just driven
  task automatic step_model();
    logic wr;
    logic hit;
    logic in_win;
    wr      = !ce && !rw;
    hit     = (m_x == 0) && (m_y == m_cmp);  // line start of the compare line
    in_win  = (m_x >= win_x0) && (m_x <= win_x1) && (m_y >= win_y0) && (m_y <= win_y1);
    exp_hs  = (m_x < h_sync_len);
    exp_vs  = (m_y < v_sync_len);
    exp_act = (m_x >= h_sync_len) && (m_y >= v_sync_len);
    exp_rgb = !exp_act ? '0 : (in_win ? palette[m_bg] : palette[m_border]);
    if (hit) begin
      m_stat = 1'b1;  // set beats a clear in the same cycle
    end else if (wr && (adl == reg_irq_stat) && drv_data[0]) begin
      m_stat = 1'b0;
    end
    if (wr) begin
      case (adl)
        reg_raster: m_cmp    = drv_data[5:0];
        reg_irq_en: m_en     = drv_data[0];
        reg_border: m_border = drv_data[3:0];
        reg_bg:     m_bg     = drv_data[3:0];
        default: ;
      endcase
    end
    m_x = m_x + 1;
    if (m_x == h_total) begin
      m_x = 0;
      m_y = (m_y + 1) % v_total;
    end
  endtask

  task automatic bus_cycle(input logic c, input logic r, input logic [5:0] a,
                           input logic [7:0] d);
    @(negedge clk_dot4x);
    check_outputs();  // results of the previous edge and of the held access
    ce       = c;
    rw       = r;
    adl      = a;
    drv_data = d;
    dbh      = d[7:4];     // upper nibble of a write comes on the colour lines
    dbl_oe   = !c && !r;   // cpu drives dbl only when writing
    step_model();
  endtask

  task automatic idle();
    logic [31:0] r;
    r = $random(seed);
    bus_cycle(1'b1, r[0], r[6:1], r[15:8]);  // random lines, chip not selected
  endtask

  initial begin
    logic [31:0] r;
    logic [5:0]  addr;
    logic [5:0]  line;
    int          waited;
    arst_n   = 1'b0;
    ce       = 1'b1;
    rw       = 1'b1;
    adl      = '0;
    dbh      = '0;
    drv_data = '0;
    dbl_oe   = 1'b0;
    m_x      = 0;
    m_y      = 0;
    m_cmp    = '0;
    m_stat   = 1'b0;
    m_en     = 1'b0;
    m_border = '0;
    m_bg     = '0;
    exp_hs   = 1'b0;  // pixel stage holds everything low in reset
    exp_vs   = 1'b0;
    exp_act  = 1'b0;
    exp_rgb  = '0;
    repeat (5) begin
      @(negedge clk_dot4x);
      check_outputs();
    end
    arst_n = 1'b1;
    step_model();  // first edge shows the pixel for x 0, y 0
    for (int i = 0; i < 5; i++) begin
      bus_cycle(1'b0, 1'b1, reset_addrs[i], 8'h00);  // reset values
    end
    repeat (rand_accesses) begin
      r    = $random(seed);
      addr = pick_addr(r);
      bus_cycle(r[3], r[4], addr, r[23:16]);
      if (!r[3] && !r[4] && (r[2:0] < 3'd5)) begin
        bus_cycle(1'b0, 1'b1, addr, 8'h00);  // read back the write
      end
    end
    // raster interrupt on a random line
    r    = $random(seed);
    line = 6'(r[15:0] % v_total);
    bus_cycle(1'b0, 1'b0, reg_irq_en, 8'h01);
    bus_cycle(1'b0, 1'b0, reg_raster, {2'b00, line});
    bus_cycle(1'b0, 1'b0, reg_irq_stat, 8'h01);  // drop any stale flag
    idle();
    waited = 0;
    while (irq && (waited < frame_len)) begin
      idle();
      waited++;
    end
    if (irq) begin
      errors++;
      $display("raster interrupt for line %0d never asserted within a frame", line);
    end
    repeat (100) idle();  // irq holds low until the flag is cleared
    bus_cycle(1'b0, 1'b0, reg_irq_stat, 8'h01);
    bus_cycle(1'b0, 1'b0, reg_irq_en, 8'h00);
    repeat (frame_len) idle();  // flag sets again but irq stays high
    bus_cycle(1'b0, 1'b1, reg_irq_stat, 8'h00);
    idle();
    $display("closing summary: %0d check errors, %0d assertion errors", errors,
             i_dut.i_vicii.i_props.fail_count);
    if ((errors == 0) && (i_dut.i_vicii.i_props.fail_count == 0)) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_top

/* filelist.f */
design/vic_pkg.sv
design/vic_regs.sv
design/raster_counter.sv
design/pixel_color.sv
design/vicii.sv
design/top.sv
testbench/tb_top_properties.sv
testbench/tb_top.sv

/* Bender.yml */
package:
  name: vicii_lite

sources:
  - design/vic_pkg.sv
  - design/vic_regs.sv
  - design/raster_counter.sv
  - design/pixel_color.sv
  - design/vicii.sv
  - design/top.sv
  - target: test
    files:
      - testbench/tb_top_properties.sv
      - testbench/tb_top.sv
